/* hw/uart_string_defs.svh */
/*
 * String link over UART, build constants.
 * Bit time in clocks, string capacity in bytes and the frame mark byte.
 */
`ifndef UART_STRING_DEFS_SVH
`define UART_STRING_DEFS_SVH

// clocks per serial bit in both directions.
`define CLKS_PER_BIT 8

// largest string the link carries in one frame.
`define MAX_CHARS 16

// the "&" byte that opens and closes every frame.
`define FRAME_MARK 8'h26

`endif

/* hw/uart_string_pkg.sv */
/*
 * String link over UART, shared types.
 * Width typedefs, the frame state encodings and the byte and write structs.
 */
package uart_string_pkg;

`include "uart_string_defs.svh"

	typedef logic [7:0] byte_t;
	typedef logic [$clog2(`MAX_CHARS + 1) - 1:0] len_t;
	typedef logic [`MAX_CHARS * 8 - 1:0] str_t;

	// transmit frame sequence with two marks on each side of the content.
	typedef enum logic [2:0] {
		TX_IDLE, TX_MARK1, TX_MARK2, TX_CONTENT, TX_MARK3, TX_MARK4, TX_FINISH
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE, RX_OPEN1, RX_OPEN2, RX_CONTENT, RX_CLOSE1, RX_FINISH
	} rx_state_t;

	typedef struct packed {
		logic  vld;
		byte_t data;
	} ser_byte_t;

	// with two set the buffer stores a mark first, then data.
	typedef struct packed {
		logic  wr;
		logic  two;
		byte_t data;
	} rx_wr_t;

endpackage

/* hw/uart_tx.sv */
/*
 * UART byte serializer, 8N1.
 * A start strobe loads the byte; start, data LSB first and stop bits follow,
 * each CLKS_PER_BIT clocks long, and byte_done marks the end of the stop bit.
 */
`timescale 1ns/1ps
`include "uart_string_defs.svh"

module uart_tx (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  uart_string_pkg::ser_byte_t cmd,
	output logic                     byte_done,
	output logic                     txd
);
	import uart_string_pkg::*;

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_PRE = CNT_W'(`CLKS_PER_BIT - 2);

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	byte_t            shreg;

	// bit_cnt 0 is the start bit, 1 to 8 the data bits and 9 the stop bit.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			// raised one clock early so the pulse sits in the last stop-bit cycle.
			byte_done <= busy && (bit_cnt == 4'd9) && (clk_cnt == CNT_PRE);
			if (!busy) begin
				if (cmd.vld) begin
					busy <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= '0;
					txd <= 1'b0;
				end
			end else if (clk_cnt != CNT_LAST) begin
				clk_cnt <= clk_cnt + 1'b1;
			end else begin
				clk_cnt <= '0;
				bit_cnt <= bit_cnt + 4'd1;
				case (bit_cnt)
					4'd9: busy <= 1'b0;
					4'd8: txd <= 1'b1;
					default: txd <= shreg[0];
				endcase
			end
		end
	end

	// the byte shifts right after each bit, so the next data bit waits in bit 0.
	always_ff @(posedge sys_clk) begin
		if (!busy && cmd.vld) begin
			shreg <= cmd.data;
		end else if (busy && clk_cnt == CNT_LAST && bit_cnt < 4'd8) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

endmodule

/* hw/uart_rx.sv */
/*
 * UART byte deserializer, 8N1.
 * Two-flop input synchronizer, start-edge detection and mid-bit sampling;
 * a byte is flagged valid in the middle of a stop bit that reads high.
 */
`timescale 1ns/1ps
`include "uart_string_defs.svh"

module uart_rx (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       rxd,
	output uart_string_pkg::ser_byte_t rx_byte
);
	import uart_string_pkg::*;

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(`CLKS_PER_BIT / 2 - 1);

	logic             rxd_s1;
	logic             rxd_s2;
	logic             busy;
	logic             vld_q;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	byte_t            shreg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
		end else begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
		end
	end

	// a falling edge shows as s1 low while s2 is still high.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			vld_q <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			vld_q <= 1'b0;
			if (!busy) begin
				if (!rxd_s1 && rxd_s2) begin
					busy <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= '0;
				end
			end else begin
				clk_cnt <= (clk_cnt == CNT_LAST) ? '0 : clk_cnt + 1'b1;
				if (clk_cnt == CNT_LAST) begin
					bit_cnt <= bit_cnt + 4'd1;
				end
				if (clk_cnt == CNT_MID) begin
					// a start bit that is high again at mid-bit was a glitch.
					if (bit_cnt == 4'd0 && rxd_s2) begin
						busy <= 1'b0;
					end else if (bit_cnt == 4'd9) begin
						busy <= 1'b0;
						vld_q <= rxd_s2;
					end
				end
			end
		end
	end

	// data bits enter at the top, so bit 0 ends up at the bottom.
	always_ff @(posedge sys_clk) begin
		if (busy && clk_cnt == CNT_MID && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
			shreg <= {rxd_s2, shreg[7:1]};
		end
	end

	assign rx_byte = {vld_q, shreg};

endmodule

/* hw/frame_ctrl.sv */
/*
 * Frame control for the string link.
 * The transmit FSM wraps the latched string in "&&" marks byte by byte;
 * the receive FSM finds "&&" frames on the serial line and issues writes.
 */
`timescale 1ns/1ps
`include "uart_string_defs.svh"

module frame_ctrl (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       tx_req,
	input  uart_string_pkg::len_t      tx_len_q,
	input  uart_string_pkg::byte_t     tx_byte,
	input  logic                       byte_done,
	input  uart_string_pkg::ser_byte_t rx_byte,
	output logic                       tx_load,
	output uart_string_pkg::len_t      tx_idx,
	output uart_string_pkg::ser_byte_t tx_cmd,
	output logic                       tx_busy,
	output logic                       tx_done,
	output uart_string_pkg::rx_wr_t    rx_wr,
	output logic                       rx_clr,
	output logic                       rx_busy,
	output logic                       rx_done
);
	import uart_string_pkg::*;

	tx_state_t tx_state;
	rx_state_t rx_state;
	logic      rx_mark;
	logic      rx_other;

	assign tx_load = (tx_state == TX_IDLE) && tx_req;
	assign tx_busy = (tx_state != TX_IDLE);
	assign tx_done = (tx_state == TX_FINISH);

	// every strobe is issued one cycle after the byte_done of the byte before.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= TX_IDLE;
			tx_idx <= '0;
			tx_cmd <= '0;
		end else begin
			tx_cmd.vld <= 1'b0;
			case (tx_state)
				TX_IDLE: begin
					tx_idx <= '0;
					if (tx_req) begin
						tx_cmd <= {1'b1, `FRAME_MARK};
						tx_state <= TX_MARK1;
					end
				end
				TX_MARK1: if (byte_done) begin
					tx_cmd <= {1'b1, `FRAME_MARK};
					tx_state <= TX_MARK2;
				end
				// an empty string drops straight through to the closing marks.
				TX_MARK2, TX_CONTENT: if (byte_done) begin
					if (tx_idx == tx_len_q) begin
						tx_cmd <= {1'b1, `FRAME_MARK};
						tx_state <= TX_MARK3;
					end else begin
						tx_cmd <= {1'b1, tx_byte};
						tx_idx <= tx_idx + 1'b1;
						tx_state <= TX_CONTENT;
					end
				end
				TX_MARK3: if (byte_done) begin
					tx_cmd <= {1'b1, `FRAME_MARK};
					tx_state <= TX_MARK4;
				end
				TX_MARK4: if (byte_done) begin
					tx_state <= TX_FINISH;
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	assign rx_mark = rx_byte.vld && (rx_byte.data == `FRAME_MARK);
	assign rx_other = rx_byte.vld && (rx_byte.data != `FRAME_MARK);

	// a lone mark inside the content is data, stored together with its successor.
	assign rx_wr = {rx_other && (rx_state == RX_CONTENT || rx_state == RX_CLOSE1),
		rx_state == RX_CLOSE1, rx_byte.data};
	assign rx_clr = (rx_state == RX_OPEN2);
	assign rx_busy = (rx_state != RX_IDLE);
	assign rx_done = (rx_state == RX_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= RX_IDLE;
		end else begin
			case (rx_state)
				RX_IDLE: if (rx_mark) rx_state <= RX_OPEN1;
				RX_OPEN1: begin
					if (rx_mark) begin
						rx_state <= RX_OPEN2;
					end else if (rx_other) begin
						rx_state <= RX_IDLE;
					end
				end
				RX_OPEN2: rx_state <= RX_CONTENT;
				RX_CONTENT: if (rx_mark) rx_state <= RX_CLOSE1;
				RX_CLOSE1: begin
					if (rx_mark) begin
						rx_state <= RX_FINISH;
					end else if (rx_other) begin
						rx_state <= RX_CONTENT;
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

endmodule

/* hw/tx_string_buf.sv */
/*
 * Transmit string buffer.
 * Captures the outgoing string and its clamped length on load and
 * selects the byte at the current send index.
 */
`timescale 1ns/1ps
`include "uart_string_defs.svh"

module tx_string_buf (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   tx_load,
	input  uart_string_pkg::str_t  tx_string,
	input  uart_string_pkg::len_t  tx_length,
	input  uart_string_pkg::len_t  tx_idx,
	output uart_string_pkg::len_t  tx_len_q,
	output uart_string_pkg::byte_t tx_byte
);
	import uart_string_pkg::*;

	localparam int IDX_W = $clog2(`MAX_CHARS);
	localparam len_t LEN_MAX = len_t'(`MAX_CHARS);

	str_t str_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			str_q <= '0;
			tx_len_q <= '0;
		end else if (tx_load) begin
			str_q <= tx_string;
			tx_len_q <= (tx_length > LEN_MAX) ? LEN_MAX : tx_length;
		end
	end

	// the index only reaches MAX_CHARS after the last byte has gone out.
	assign tx_byte = str_q[{tx_idx[IDX_W-1:0], 3'b000} +: 8];

endmodule

/* hw/rx_string_buf.sv */
/*
 * Receive string buffer.
 * Stores one or two bytes per write at the current length and counts the
 * length up to MAX_CHARS; bytes past the capacity are dropped.
 */
`timescale 1ns/1ps
`include "uart_string_defs.svh"

module rx_string_buf (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    rx_clr,
	input  uart_string_pkg::rx_wr_t rx_wr,
	output uart_string_pkg::str_t   rx_string,
	output uart_string_pkg::len_t   rx_length
);
	import uart_string_pkg::*;

	localparam int LEN_W = $bits(len_t);
	localparam len_t LEN_MAX = len_t'(`MAX_CHARS);

	logic [LEN_W:0] len_sum;
	len_t           len_next;
	len_t           len_p1;

	assign len_p1 = rx_length + 1'b1;
	assign len_sum = {1'b0, rx_length} + (rx_wr.two ? 2'd2 : 2'd1);
	assign len_next = (len_sum > {1'b0, LEN_MAX}) ? LEN_MAX : len_sum[LEN_W-1:0];

	// a clear resets only the length and leaves the old bytes above it in place.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_string <= '0;
			rx_length <= '0;
		end else if (rx_clr) begin
			rx_length <= '0;
		end else if (rx_wr.wr) begin
			rx_length <= len_next;
			for (int k = 0; k < `MAX_CHARS; k++) begin
				if (rx_length == len_t'(k)) begin
					rx_string[k*8 +: 8] <= rx_wr.two ? `FRAME_MARK : rx_wr.data;
				end
				if (rx_wr.two && len_p1 == len_t'(k)) begin
					rx_string[k*8 +: 8] <= rx_wr.data;
				end
			end
		end
	end

endmodule

/* hw/uart_string_top.sv */
/*
 * String link over UART, top level.
 * Frame control, the two string buffers and the UART engines.
 */
`timescale 1ns/1ps
`include "uart_string_defs.svh"

module uart_string_top (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  uart_string_pkg::str_t tx_string,
	input  uart_string_pkg::len_t tx_length,
	input  logic                  tx_req,
	output logic                  tx_busy,
	output logic                  tx_done,
	output uart_string_pkg::str_t rx_string,
	output uart_string_pkg::len_t rx_length,
	output logic                  rx_busy,
	output logic                  rx_done,
	input  logic                  uart_rx_port,
	output logic                  uart_tx_port
);
	import uart_string_pkg::*;

	logic      tx_load;
	len_t      tx_idx;
	len_t      tx_len_q;
	byte_t     tx_byte;
	ser_byte_t tx_cmd;
	logic      byte_done;
	ser_byte_t rx_byte;
	rx_wr_t    rx_wr;
	logic      rx_clr;

	frame_ctrl u_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_len_q  (tx_len_q),
		.tx_byte   (tx_byte),
		.byte_done (byte_done),
		.rx_byte   (rx_byte),
		.tx_load   (tx_load),
		.tx_idx    (tx_idx),
		.tx_cmd    (tx_cmd),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_wr     (rx_wr),
		.rx_clr    (rx_clr),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

	tx_string_buf u_txbuf (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_load   (tx_load),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_idx    (tx_idx),
		.tx_len_q  (tx_len_q),
		.tx_byte   (tx_byte)
	);

	rx_string_buf u_rxbuf (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_clr    (rx_clr),
		.rx_wr     (rx_wr),
		.rx_string (rx_string),
		.rx_length (rx_length)
	);

	uart_tx u_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cmd       (tx_cmd),
		.byte_done (byte_done),
		.txd       (uart_tx_port)
	);

	uart_rx u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte)
	);

endmodule

/* tests/tb_uart_string.sv */
/*
 * Testbench for the UART string link.
 * Random frames in both directions, a serial driver and line monitor,
 * a framing reference model and a cycle-count timeout.
 */
`timescale 1ns/1ps
`include "uart_string_defs.svh"

module tb_uart_string;
	import uart_string_pkg::*;

	localparam int MS_IDLE = 0;
	localparam int MS_OPEN = 1;
	localparam int MS_CONTENT = 2;
	localparam int MS_CLOSE = 3;

	// the run limit counts every frame byte at its largest possible size.
	localparam int FRAME_BYTES = 40 * (`MAX_CHARS + 4) + 4 * (2 * `MAX_CHARS + 4)
		+ (`MAX_CHARS + 6) + 3 * (`MAX_CHARS + 12) + 2 * (`MAX_CHARS + 4);
	localparam int TIMEOUT_CYCLES = FRAME_BYTES * 10 * `CLKS_PER_BIT * 3 / 2 + 16;

	logic  sys_clk;
	logic  sys_rst_n;
	str_t  tx_string;
	len_t  tx_length;
	logic  tx_req;
	logic  tx_busy;
	logic  tx_done;
	str_t  rx_string;
	len_t  rx_length;
	logic  rx_busy;
	logic  rx_done;
	logic  uart_rx_port;
	logic  uart_tx_port;

	logic [31:0] lfsr_state = 32'h1d93;
	int          cycle_cnt = 0;
	int          val_errs = 0;
	int          other_errs = 0;
	int          tx_frames = 0;
	int          tx_done_cnt = 0;
	int          rx_done_cnt = 0;

	byte_t tx_seen[$];
	byte_t rx_stream[$];
	int    exp_rx_len[$];
	str_t  exp_rx_str[$];
	int    model_state = MS_IDLE;
	int    model_len = 0;
	str_t  model_str = '0;

	uart_string_top u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	always #20 sys_clk = ~sys_clk;

	// fibonacci LFSR with taps 32, 22, 2 and 1 that is stepped once per bit taken.
	function automatic logic [31:0] rand_val(input int nbits);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic byte_t rand_content_byte();
		byte_t b;
		b = byte_t'(rand_val(8));
		if (b == `FRAME_MARK) begin
			b = b ^ 8'h01;
		end
		return b;
	endfunction

	task automatic value_error(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		$display("ERR %s exp %h got %h", name, exp_v, got_v);
		val_errs++;
	endtask

	task automatic other_error(input string what);
		$display("error: %s", what);
		other_errs++;
	endtask

	function automatic void model_store(input byte_t b);
		if (model_len < `MAX_CHARS) begin
			model_str[model_len*8 +: 8] = b;
			model_len++;
		end
	endfunction

	// receive framing rules applied to every byte put on the serial line.
	function automatic void model_rx_byte(input byte_t b);
		case (model_state)
			MS_IDLE: begin
				if (b == `FRAME_MARK) begin
					model_state = MS_OPEN;
				end
			end
			MS_OPEN: begin
				if (b == `FRAME_MARK) begin
					model_state = MS_CONTENT;
					model_len = 0;
				end else begin
					model_state = MS_IDLE;
				end
			end
			MS_CONTENT: begin
				if (b == `FRAME_MARK) begin
					model_state = MS_CLOSE;
				end else begin
					model_store(b);
				end
			end
			default: begin
				if (b == `FRAME_MARK) begin
					exp_rx_len.push_back(model_len);
					exp_rx_str.push_back(model_str);
					model_state = MS_IDLE;
				end else begin
					model_store(`FRAME_MARK);
					model_store(b);
					model_state = MS_CONTENT;
				end
			end
		endcase
	endfunction

	// each bit starts right after a rising edge and the line is left high at the end.
	task automatic drive_serial_byte(input byte_t b);
		logic [9:0] line_bits;
		line_bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx_port <= line_bits[i];
			repeat (`CLKS_PER_BIT) @(posedge sys_clk);
		end
	endtask

	task automatic send_rx_stream();
		byte_t b;
		@(posedge sys_clk);
		while (rx_stream.size() > 0) begin
			b = rx_stream.pop_front();
			model_rx_byte(b);
			drive_serial_byte(b);
		end
	endtask

	// with_marks puts a single mark before some content bytes.
	task automatic build_rx_frame(input int n_chars, input bit with_marks);
		rx_stream.push_back(`FRAME_MARK);
		rx_stream.push_back(`FRAME_MARK);
		for (int k = 0; k < n_chars; k++) begin
			if (with_marks && rand_val(2) == 0) begin
				rx_stream.push_back(`FRAME_MARK);
			end
			rx_stream.push_back(rand_content_byte());
		end
		rx_stream.push_back(`FRAME_MARK);
		rx_stream.push_back(`FRAME_MARK);
	endtask

	task automatic make_tx_string(output str_t s, output len_t len);
		len = len_t'(rand_val(5) % (`MAX_CHARS + 1));
		for (int k = 0; k < `MAX_CHARS; k++) begin
			s[k*8 +: 8] = rand_content_byte();
		end
	endtask

	task automatic send_tx_frame(input str_t s, input len_t len);
		byte_t exp_q[$];
		byte_t got;
		exp_q.push_back(`FRAME_MARK);
		exp_q.push_back(`FRAME_MARK);
		for (int k = 0; k < int'(len); k++) begin
			exp_q.push_back(s[k*8 +: 8]);
		end
		exp_q.push_back(`FRAME_MARK);
		exp_q.push_back(`FRAME_MARK);
		@(posedge sys_clk);
		tx_string <= s;
		tx_length <= len;
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		@(negedge sys_clk);
		if (tx_busy != 1'b1) begin
			value_error("tx_busy", 32'(1), 32'(tx_busy));
		end
		// a second request while busy must not start another frame.
		@(posedge sys_clk);
		tx_length <= ~len;
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		@(negedge sys_clk);
		while (!tx_done) begin
			@(negedge sys_clk);
		end
		tx_frames++;
		if (tx_seen.size() != exp_q.size()) begin
			value_error("uart_tx_port byte count", 32'(exp_q.size()), 32'(tx_seen.size()));
			tx_seen.delete();
		end else begin
			for (int k = 0; k < exp_q.size(); k++) begin
				got = tx_seen.pop_front();
				if (got != exp_q[k]) begin
					value_error($sformatf("uart_tx_port byte %0d", k), 32'(exp_q[k]),
						32'(got));
				end
			end
		end
	endtask

	// uart_tx_port is decoded at mid-bit on the falling clock edge.
	initial begin : tx_line_monitor
		byte_t b;
		@(posedge sys_rst_n);
		forever begin
			@(negedge sys_clk);
			if (uart_tx_port == 1'b0) begin
				repeat (`CLKS_PER_BIT / 2) @(negedge sys_clk);
				if (uart_tx_port != 1'b0) begin
					other_error("uart_tx_port start bit did not hold low");
				end else begin
					for (int i = 0; i < 8; i++) begin
						repeat (`CLKS_PER_BIT) @(negedge sys_clk);
						b[i] = uart_tx_port;
					end
					repeat (`CLKS_PER_BIT) @(negedge sys_clk);
					if (uart_tx_port != 1'b1) begin
						other_error("uart_tx_port stop bit was low");
					end
					tx_seen.push_back(b);
				end
			end
		end
	end

	always @(negedge sys_clk) begin
		if (sys_rst_n && tx_done) begin
			tx_done_cnt++;
		end
	end

	always @(negedge sys_clk) begin : rx_done_check
		int   exp_len;
		str_t exp_str;
		if (sys_rst_n && rx_done) begin
			rx_done_cnt++;
			if (exp_rx_len.size() == 0) begin
				other_error("rx_done pulsed with no frame closed on the line");
			end else begin
				exp_len = exp_rx_len.pop_front();
				exp_str = exp_rx_str.pop_front();
				if (rx_length != len_t'(exp_len)) begin
					value_error("rx_length", 32'(exp_len), 32'(rx_length));
				end
				for (int k = 0; k < exp_len; k++) begin
					if (rx_string[k*8 +: 8] != exp_str[k*8 +: 8]) begin
						value_error($sformatf("rx_string byte %0d", k),
							32'(exp_str[k*8 +: 8]), 32'(rx_string[k*8 +: 8]));
					end
				end
			end
		end
	end

	initial begin : watchdog
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : main_seq
		str_t  s;
		len_t  len;
		byte_t letter;
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		uart_rx_port = 1'b1;
		repeat (16) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		if (tx_busy != 1'b0) begin
			value_error("tx_busy", 32'(0), 32'(tx_busy));
		end
		if (tx_done != 1'b0) begin
			value_error("tx_done", 32'(0), 32'(tx_done));
		end
		if (rx_busy != 1'b0) begin
			value_error("rx_busy", 32'(0), 32'(rx_busy));
		end
		if (rx_done != 1'b0) begin
			value_error("rx_done", 32'(0), 32'(rx_done));
		end
		if (uart_tx_port != 1'b1) begin
			value_error("uart_tx_port", 32'(1), 32'(uart_tx_port));
		end

		for (int f = 0; f < 20; f++) begin
			make_tx_string(s, len);
			send_tx_frame(s, len);
		end

		for (int f = 0; f < 20; f++) begin
			build_rx_frame(int'(rand_val(5) % (`MAX_CHARS + 1)), 1'b0);
			send_rx_stream();
		end

		for (int f = 0; f < 4; f++) begin
			build_rx_frame(1 + int'(rand_val(4) % `MAX_CHARS), 1'b1);
			send_rx_stream();
		end

		// a mark and a letter ahead of a frame are noise.
		letter = 8'h41 + 8'(rand_val(5) % 26);
		rx_stream.push_back(`FRAME_MARK);
		rx_stream.push_back(letter);
		build_rx_frame(int'(rand_val(5) % (`MAX_CHARS + 1)), 1'b0);
		send_rx_stream();

		for (int f = 0; f < 3; f++) begin
			build_rx_frame(`MAX_CHARS + 1 + int'(rand_val(3)), 1'b0);
			send_rx_stream();
		end

		make_tx_string(s, len);
		build_rx_frame(`MAX_CHARS, 1'b0);
		fork
			send_tx_frame(s, len);
			send_rx_stream();
		join

		repeat (2 * 10 * `CLKS_PER_BIT) @(posedge sys_clk);
		if (exp_rx_len.size() != 0) begin
			other_error($sformatf("%0d received frames never gave rx_done",
				exp_rx_len.size()));
		end
		if (tx_seen.size() != 0) begin
			other_error("uart_tx_port carried bytes outside any requested frame");
		end
		if (tx_done_cnt != tx_frames) begin
			value_error("tx_done count", 32'(tx_frames), 32'(tx_done_cnt));
		end

		$display("tx frames %0d, rx frames %0d, value errors %0d, other errors %0d",
			tx_frames, rx_done_cnt, val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+hw
hw/uart_string_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/frame_ctrl.sv
hw/tx_string_buf.sv
hw/rx_string_buf.sv
hw/uart_string_top.sv
tests/tb_uart_string.sv

/* run_sim.sh */
#!/bin/sh
# Builds the string link testbench with Verilator and runs it.

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
	--top-module tb_uart_string -o tb_uart_string
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_uart_string)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
